// ==== list.f ====
+incdir+source
source/rv_core_pkg.sv
source/instr_decoder.sv
source/reg_file.sv
source/alu.sv
source/program_counter.sv
source/rv_core.sv
tb/rv_core_assert.sv
tb/rv_core_tb.sv

// ==== run.sh ====
#!/bin/bash
# build the testbench with verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module rv_core_tb -o rv_core_sim || exit 1
out=$(./obj_dir/rv_core_sim 2>&1)
echo "$out"
echo "$out" | grep -q "All tests passed" && exit 0 || exit 1

// ==== source/alu.sv ====
`include "rv_core_cfg.svh"

module alu import rv_core_pkg::*; (
  input  word_t   a,
  input  word_t   b,
  input  alu_op_t op,
  output word_t   result,
  output logic    zero
);

  // shift amount width, 5 for a 32-bit word
  localparam int SHAMT_W = $clog2(`XLEN);

  logic [SHAMT_W-1:0] shamt;

  assign shamt = b[SHAMT_W-1:0];

  always_comb begin
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_SLL:  result = a << shamt;
      // set-less-than gives 1 when a < b
      ALU_SLT:  result = word_t'($signed(a) < $signed(b));
      ALU_SLTU: result = word_t'(a < b);
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> shamt;
      // arithmetic shift keeps the sign
      ALU_SRA:  result = word_t'($signed(a) >>> shamt);
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      default:  result = '0;
    endcase
  end

  // branch compare uses this after sub
  assign zero = (result == '0);

endmodule

// ==== source/instr_decoder.sv ====
module instr_decoder import rv_core_pkg::*; (
  input  word_t    instr,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output reg_idx_t rd,
  output word_t    imm,
  output alu_op_t  alu_op,
  output src_a_t   src_a_sel,
  output logic     src_b_imm,
  output wb_sel_t  wb_sel,
  output logic     reg_we,
  output logic     d_we,
  output logic     is_branch,
  output logic     branch_ne
);

  opcode_t    opcode;
  logic [2:0] funct3;

  // funct3 plus the alternate bit (instr[30]) to alu operation
  function automatic alu_op_t funct_to_alu(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // fixed field positions
  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  always_comb begin
    // defaults: no write, no branch
    imm       = '0;
    alu_op    = ALU_ADD;
    src_a_sel = SRC_A_REG;
    src_b_imm = 1'b0;
    wb_sel    = WB_ALU;
    reg_we    = 1'b0;
    d_we      = 1'b0;
    is_branch = 1'b0;
    branch_ne = 1'b0;
    case (opcode)
      OP_REG: begin
        alu_op = funct_to_alu(funct3, instr[30]);
        reg_we = 1'b1;
      end
      OP_IMM: begin
        // bit 30 only selects sra among immediates
        imm       = {{20{instr[31]}}, instr[31:20]};
        alu_op    = funct_to_alu(funct3, (funct3 == 3'b101) & instr[30]);
        src_b_imm = 1'b1;
        reg_we    = 1'b1;
      end
      OP_LOAD: begin
        // lw only
        imm       = {{20{instr[31]}}, instr[31:20]};
        src_b_imm = 1'b1;
        wb_sel    = WB_MEM;
        reg_we    = (funct3 == 3'b010);
      end
      OP_STORE: begin
        // sw only, s-type immediate
        imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        src_b_imm = 1'b1;
        d_we      = (funct3 == 3'b010);
      end
      OP_BRANCH: begin
        // beq/bne compare by subtraction
        imm       = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        alu_op    = ALU_SUB;
        is_branch = (funct3[2:1] == 2'b00);
        branch_ne = funct3[0];
      end
      OP_LUI: begin
        imm       = {instr[31:12], 12'b0};
        src_a_sel = SRC_A_ZERO;
        src_b_imm = 1'b1;
        reg_we    = 1'b1;
      end
      OP_AUIPC: begin
        imm       = {instr[31:12], 12'b0};
        src_a_sel = SRC_A_PC;
        src_b_imm = 1'b1;
        reg_we    = 1'b1;
      end
      default: begin
        // unknown opcode, nothing written
      end
    endcase
  end

endmodule

// ==== source/program_counter.sv ====
`include "rv_core_cfg.svh"

module program_counter import rv_core_pkg::*; (
  input  logic       CLK,
  input  logic       RESET_N,
  input  word_t      imm,
  input  logic       is_branch,
  input  logic       branch_ne,
  input  logic       zero,
  output byte_addr_t pc
);

  logic       take;
  byte_addr_t next_pc;

  // beq taken on zero, bne taken on nonzero
  assign take = is_branch && (zero != branch_ne);

  // target or sequential step
  // both wrap at ADDR_WIDTH bits
  assign next_pc = take ? pc + imm[`ADDR_WIDTH-1:0]
                        : pc + byte_addr_t'(4);

  always_ff @(posedge CLK or negedge RESET_N) begin
    if (!RESET_N) begin
      pc <= '0;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

// ==== source/reg_file.sv ====
`include "rv_core_cfg.svh"

module reg_file import rv_core_pkg::*; (
  input  logic     CLK,
  input  logic     RESET_N,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  word_t    wdata,
  input  logic     we,
  output word_t    rdata1,
  output word_t    rdata2
);

  word_t regs [`REG_COUNT];

  // write on rising edge, x0 never written
  always_ff @(posedge CLK or negedge RESET_N) begin
    if (!RESET_N) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // combinational reads
  // x0 forced to zero
  assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== source/rv_core.sv ====
`include "rv_core_cfg.svh"

module rv_core import rv_core_pkg::*; (
  input  logic       CLK,
  input  logic       RESET_N,
  input  word_t      idata,
  output word_addr_t iaddr,
  input  word_t      ddata_r,
  output word_addr_t daddr,
  output word_t      ddata_w,
  output logic       d_we
);

  reg_idx_t   rs1;
  reg_idx_t   rs2;
  reg_idx_t   rd;
  word_t      imm;
  alu_op_t    alu_op;
  src_a_t     src_a_sel;
  logic       src_b_imm;
  wb_sel_t    wb_sel;
  logic       reg_we;
  logic       is_branch;
  logic       branch_ne;
  word_t      rdata1;
  word_t      rdata2;
  word_t      op_a;
  word_t      op_b;
  word_t      alu_result;
  logic       alu_zero;
  word_t      wb_data;
  byte_addr_t pc;

  instr_decoder i_decoder (
    .instr(idata), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
    .alu_op(alu_op), .src_a_sel(src_a_sel), .src_b_imm(src_b_imm),
    .wb_sel(wb_sel), .reg_we(reg_we), .d_we(d_we),
    .is_branch(is_branch), .branch_ne(branch_ne)
  );

  reg_file i_reg_file (
    .CLK(CLK), .RESET_N(RESET_N), .rs1(rs1), .rs2(rs2), .rd(rd),
    .wdata(wb_data), .we(reg_we), .rdata1(rdata1), .rdata2(rdata2)
  );

  // first operand, pc zero-extended for auipc
  always_comb begin
    case (src_a_sel)
      SRC_A_REG: op_a = rdata1;
      SRC_A_PC:  op_a = word_t'(pc);
      default:   op_a = '0;
    endcase
  end

  // second operand
  assign op_b = src_b_imm ? imm : rdata2;

  alu i_alu (
    .a(op_a), .b(op_b), .op(alu_op), .result(alu_result), .zero(alu_zero)
  );

  // load data or alu result back to rd
  assign wb_data = (wb_sel == WB_MEM) ? ddata_r : alu_result;

  program_counter i_pc (
    .CLK(CLK), .RESET_N(RESET_N), .imm(imm), .is_branch(is_branch),
    .branch_ne(branch_ne), .zero(alu_zero), .pc(pc)
  );

  // word addresses for both memories
  assign iaddr   = pc[`ADDR_WIDTH-1:2];
  assign daddr   = alu_result[`ADDR_WIDTH-1:2];
  assign ddata_w = rdata2;

endmodule

// ==== source/rv_core_cfg.svh ====
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// datapath width, one RV32I word
`define XLEN 32

// byte address width of pc and data addresses
// low two bits dropped on the memory ports
`define ADDR_WIDTH 10

// architectural integer registers
`define REG_COUNT 32

`endif

// ==== source/rv_core_pkg.sv ====
`include "rv_core_cfg.svh"

package rv_core_pkg;

  // one data word
  typedef logic [`XLEN-1:0] word_t;

  // byte address, pc and branch target
  typedef logic [`ADDR_WIDTH-1:0] byte_addr_t;

  // word address for the memory ports
  typedef logic [`ADDR_WIDTH-3:0] word_addr_t;

  // register index, 5 bits for 32 registers
  typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_REG    = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111
  } opcode_t;

  // alu operations
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_t;

  // first alu operand source
  // zero is used by lui
  typedef enum logic [1:0] {
    SRC_A_REG, SRC_A_PC, SRC_A_ZERO
  } src_a_t;

  // writeback source
  typedef enum logic {
    WB_ALU, WB_MEM
  } wb_sel_t;

endpackage

// ==== tb/rv_core_assert.sv ====
`include "rv_core_cfg.svh"

module rv_core_assert import rv_core_pkg::*; (
  input logic       CLK,
  input logic       RESET_N,
  input word_addr_t iaddr,
  input logic       d_we,
  input byte_addr_t pc,
  input word_t      idata,
  input word_t      rdata1,
  input word_t      rdata2
);

  // read by the testbench at the end of the run
  int unsigned fail_cnt = 0;
  logic        br_taken;
  logic [12:0] br_off;
  byte_addr_t  target;

  // beq taken on equal operands, bne on unequal ones
  assign br_taken = (idata[6:0] == 7'b1100011)
                  && ((idata[14:12] == 3'b000 && rdata1 == rdata2)
                   || (idata[14:12] == 3'b001 && rdata1 != rdata2));

  // b-type offset straight from the instruction bits
  assign br_off = {idata[31], idata[7], idata[30:25], idata[11:8], 1'b0};

  // target wraps at the pc width
  assign target = pc + br_off[`ADDR_WIDTH-1:0];

  // fetch held at word 0 while in reset
  a_reset_iaddr: assert property (@(posedge CLK) !RESET_N |-> iaddr == '0)
    else begin
      $error("iaddr not zero during reset");
      fail_cnt = fail_cnt + 1;
    end

  // store enable always driven once running
  a_dwe_known: assert property (@(posedge CLK) disable iff (!RESET_N) !$isunknown(d_we))
    else begin
      $error("d_we unknown after reset");
      fail_cnt = fail_cnt + 1;
    end

  // a taken branch lands on pc plus the offset
  a_branch_target: assert property (@(posedge CLK) disable iff (!RESET_N)
    br_taken |=> pc == $past(target))
    else begin
      $error("taken branch did not reach pc plus imm");
      fail_cnt = fail_cnt + 1;
    end

endmodule

// ==== tb/rv_core_tb.sv ====
module rv_core_tb import rv_core_pkg::*; ();

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 10;
  // cycles run after reset release, per test
  localparam int SEQ_CYC = 20;
  localparam int ALU_CYC = 30;
  localparam int MEM_CYC = 16;
  localparam int BR_CYC  = 30;
  // five resets in total, plus a margin
  localparam int WATCHDOG_CYC = SEQ_CYC + 2 * ALU_CYC + MEM_CYC + BR_CYC
                              + 5 * (RESET_CYCLES + 1) + 50;
  localparam word_t NOP = 32'h0000_0013;
  // add sub sll slt sltu xor srl sra or and
  localparam logic [2:0] OP_F3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                        3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
  // instr[30] set for sub and sra
  localparam logic [9:0] OP_ALT = 10'b0010000010;

  logic       CLK;
  logic       RESET_N;
  word_t      idata;
  word_t      ddata_r;
  word_t      ddata_w;
  word_addr_t iaddr;
  word_addr_t daddr;
  logic       d_we;
  word_t      imem [256];
  word_t      dmem [256];
  logic [7:0] wp;
  word_t      rng;

  rv_core i_dut (
    .CLK(CLK), .RESET_N(RESET_N), .idata(idata), .iaddr(iaddr),
    .ddata_r(ddata_r), .daddr(daddr), .ddata_w(ddata_w), .d_we(d_we)
  );

  bind rv_core rv_core_assert i_assert (.*);

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // untouched data words, every address distinct
  function automatic word_t fill_word(input logic [7:0] a);
    return 32'hbad0_0000 + {16'd0, ~a, a};
  endfunction

  // combinational fetch and load
  assign idata   = imem[iaddr];
  assign ddata_r = dmem[daddr];

  // refilled while in reset, stores land on the rising edge
  always @(posedge CLK) begin
    if (!RESET_N) begin
      for (int i = 0; i < 256; i++) begin
        dmem[8'(i)] <= fill_word(8'(i));
      end
    end else if (d_we) begin
      dmem[daddr] <= ddata_w;
    end
  end

  function automatic word_t xorshift32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // rv32i result of one alu operation
  function automatic word_t ref_op(input logic [2:0] f3, input logic alt,
                                   input word_t a, input word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // b-type, byte offset scrambled into the immediate fields
  function automatic word_t enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  task automatic emit(input word_t w);
    imem[wp] = w;
    wp = wp + 8'd1;
  endtask

  task automatic clear_prog();
    for (int i = 0; i < 256; i++) begin
      imem[8'(i)] = NOP;
    end
    wp = 8'd0;
  endtask

  // lui plus addi, upper part rounded for the signed low part
  task automatic load_const(input logic [4:0] rd, input word_t v);
    word_t hi;
    hi = v + 32'h800;
    emit({hi[31:12], rd, 7'b0110111});
    emit({v[11:0], rd, 3'b000, rd, 7'b0010011});
  endtask

  // sw rs, slot*4(x0)
  task automatic store(input logic [4:0] rs, input logic [7:0] slot);
    emit({2'b00, slot[7:3], rs, 5'd0, 3'b010, slot[2:0], 2'b00, 7'b0100011});
  endtask

  task automatic run_prog(input int cycles);
    @(negedge CLK);
    RESET_N = 1'b0;
    repeat (RESET_CYCLES) @(negedge CLK);
    RESET_N = 1'b1;
    repeat (cycles) @(negedge CLK);
  endtask

  task automatic check(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("[ERROR] time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      $display("Some tests failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic check_mem(input logic [7:0] slot, input word_t expected);
    check($sformatf("dmem[%0d]", slot), dmem[slot], expected);
  endtask

  task automatic test_reset_seq();
    clear_prog();
    @(negedge CLK);
    RESET_N = 1'b0;
    repeat (RESET_CYCLES) begin
      @(negedge CLK);
      check("iaddr", 32'(iaddr), 32'd0);
    end
    RESET_N = 1'b1;
    // nop only, one word per cycle and no store
    for (int k = 1; k <= SEQ_CYC; k++) begin
      @(negedge CLK);
      check("iaddr", 32'(iaddr), 32'(k));
      check("d_we", 32'(d_we), 32'd0);
    end
    check_mem(8'd0, fill_word(8'd0));
  endtask

  // ten register ops, or the nine immediate ops with addi twice
  task automatic test_alu_ops(input logic use_imm);
    word_t       a;
    word_t       b;
    word_t       rnd;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm12;
    logic [7:0]  base;
    word_t       expv [10];
    clear_prog();
    base = use_imm ? 8'd10 : 8'd0;
    // negative a exercises slt and sra
    a = xorshift32() | 32'h8000_0000;
    b = xorshift32();
    load_const(5'd1, a);
    load_const(5'd2, b);
    for (int k = 0; k < 10; k++) begin
      f3  = OP_F3[4'(k)];
      alt = OP_ALT[4'(k)];
      rnd = xorshift32();
      if (!use_imm) begin
        emit({alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3, 7'b0110011});
        expv[4'(k)] = ref_op(f3, alt, a, b);
      end else begin
        if (f3 == 3'd1 || f3 == 3'd5) begin
          imm12 = {alt ? 7'h20 : 7'h00, rnd[4:0]};
        end else begin
          // first addi positive, second negative
          imm12 = rnd[11:0];
          if (k == 0) imm12[11] = 1'b0;
          if (k == 1) imm12[11] = 1'b1;
        end
        emit({imm12, 5'd1, f3, 5'd3, 7'b0010011});
        expv[4'(k)] = ref_op(f3, alt && f3 == 3'd5, a, {{20{imm12[11]}}, imm12});
      end
      store(5'd3, base + 8'(k));
    end
    run_prog(ALU_CYC);
    for (int k = 0; k < 10; k++) begin
      check_mem(base + 8'(k), expv[4'(k)]);
    end
  endtask

  task automatic test_mem_upper();
    word_t      v;
    word_t      u;
    logic [7:0] at;
    clear_prog();
    v = xorshift32();
    u = xorshift32();
    load_const(5'd1, v);
    store(5'd1, 8'd20);
    // lw x4, 80(x0) and store it a second time
    emit({12'd80, 5'd0, 3'b010, 5'd4, 7'b0000011});
    store(5'd4, 8'd21);
    // addi x0, x1, 0 leaves x0 at zero
    emit({12'd0, 5'd1, 3'b000, 5'd0, 7'b0010011});
    store(5'd0, 8'd22);
    at = wp;
    emit({u[19:0], 5'd7, 7'b0010111});
    emit({u[19:0], 5'd8, 7'b0110111});
    store(5'd7, 8'd23);
    store(5'd8, 8'd24);
    run_prog(MEM_CYC);
    check_mem(8'd20, v);
    check_mem(8'd21, v);
    check_mem(8'd22, 32'd0);
    check_mem(8'd23, {u[19:0], 12'h000} + {22'd0, at, 2'b00});
    check_mem(8'd24, {u[19:0], 12'h000});
  endtask

  // beq taken, beq not taken, bne taken, bne not taken
  task automatic test_branch();
    word_t      v;
    logic [4:0] rs2;
    logic [7:0] t0;
    logic [7:0] t1;
    word_addr_t prev;
    clear_prog();
    v = xorshift32();
    load_const(5'd1, v);
    load_const(5'd2, v);
    load_const(5'd3, v ^ 32'h0000_0100);
    load_const(5'd5, 32'd1);
    load_const(5'd6, 32'd2);
    t0 = 8'd0;
    t1 = 8'd0;
    for (int i = 0; i < 4; i++) begin
      rs2 = (i == 0 || i == 3) ? 5'd2 : 5'd3;
      if (i == 0) t0 = wp;
      if (i == 2) t1 = wp;
      // skip over the marker store when taken
      emit(enc_b(13'd8, rs2, 5'd1, (i < 2) ? 3'b000 : 3'b001));
      store(5'd5, 8'(30 + 2 * i));
      store(5'd6, 8'(31 + 2 * i));
    end
    run_prog(0);
    prev = iaddr;
    repeat (BR_CYC) begin
      @(negedge CLK);
      if (prev == t0 || prev == t1) begin
        check("iaddr after branch", 32'(iaddr), 32'(prev) + 32'd2);
      end
      prev = iaddr;
    end
    for (int i = 0; i < 4; i++) begin
      check_mem(8'(30 + 2 * i), (i == 0 || i == 2) ? fill_word(8'(30 + 2 * i)) : 32'd1);
      check_mem(8'(31 + 2 * i), 32'd2);
    end
  endtask

  initial begin
    RESET_N = 1'b0;
    rng = 32'd38599;
    clear_prog();
    test_reset_seq();
    test_alu_ops(1'b0);
    test_alu_ops(1'b1);
    test_mem_upper();
    test_branch();
    // bound assertions count their own failures
    if (i_dut.i_assert.fail_cnt == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("Some tests failed");
      $fatal(1, "assertion failures seen");
    end
  end

  // run must end well before this
  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("timeout: tests did not finish within the cycle budget");
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

endmodule
